// File: tb.f
+incdir+verilog
verilog/spi_ctrl_pkg.sv
verilog/spi_cmd_arbiter.sv
verilog/spi_shift_engine.sv
verilog/spi_ctrl_top.sv
bench/spi_slave_model.sv
bench/tb_spi_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the SPI controller testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_spi_ctrl -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
else
  echo "simulation did not report a pass"
  exit 1
fi

// File: bench/tb_spi_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_ctrl_settings.svh"

module tb_spi_ctrl;

  import spi_ctrl_pkg::*;

  localparam int NC             = `SPI_NUM_CLIENTS;
  localparam int NUM_REGS       = 1 << `SPI_ADDR_BITS;
  localparam int NUM_RANDOM     = 40;
  localparam int TXN_PER_CLIENT = NUM_RANDOM + 3;
  localparam int FRAME_CYCLES   = 24 * `SPI_HALF_PERIOD + 8;
  localparam int RESET_CYCLES   = 8;
  localparam int CLK_PERIOD     = 20;
  localparam int LIMIT_CYCLES   = TXN_PER_CLIENT * NC * FRAME_CYCLES + RESET_CYCLES;

  logic              clk;
  logic              rst_n;
  logic [NC-1:0]     cmd_strobe;
  spi_cmd_u [NC-1:0] cmd;
  spi_rsp_t [NC-1:0] rsp;
  logic              miso;
  logic              sclk;
  logic              cs_n;
  logic              mosi;
  int                frame_errors;
  int                frame_count;
  int                pad_errors;

  // reference register file and what each client has outstanding.
  logic [`SPI_DATA_BITS-1:0] ref_regs [NUM_REGS] = '{default: '0};
  int                        issued [NC] = '{default: 0};
  int                        done_count [NC] = '{default: 0};
  logic                      exp_rd [NC];
  logic [`SPI_ADDR_BITS-1:0] exp_addr [NC];
  logic [`SPI_DATA_BITS-1:0] exp_wdata [NC];
  logic [`SPI_DATA_BITS-1:0] last_rd [NC];
  int                        first_done = -1;
  int                        mon_errors = 0;
  int                        main_errors = 0;
  int                        err_mark = 0;
  int                        tests_run = 0;
  int                        tests_failed = 0;
  integer                    seed;

  logic                      rnd_wr [NC][NUM_RANDOM];
  logic [`SPI_ADDR_BITS-1:0] rnd_addr [NC][NUM_RANDOM];
  logic [`SPI_DATA_BITS-1:0] rnd_data [NC][NUM_RANDOM];
  int                        rnd_gap [NC][NUM_RANDOM];

  spi_ctrl_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .miso       (miso),
    .rsp        (rsp),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi)
  );

  spi_slave_model u_slave (
    .sclk         (sclk),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .miso         (miso),
    .frame_errors (frame_errors),
    .frame_count  (frame_count),
    .pad_errors   (pad_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers.
  ////////////////////////////////////////////////////////////////////////////

  function automatic bit value_ok(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
    bit ok;
    ok = 1'b1;
    assert (got === want)
    else
    begin
      $display("FAIL %s: got %0h expected %0h", name, got, want);
      ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic issue_cmd(input int c, input logic wr, input logic [`SPI_ADDR_BITS-1:0] addr,
                           input logic [`SPI_DATA_BITS-1:0] data);
    spi_cmd_u word;
    // a read leaves random bits in the pad.
    word.wr_cmd.wr   = wr;
    word.wr_cmd.addr = addr;
    word.wr_cmd.data = data;
    @(posedge clk);
    exp_rd[c]     = !wr;
    exp_addr[c]   = addr;
    exp_wdata[c]  = data;
    issued[c]     = issued[c] + 1;
    cmd_strobe[c] <= 1'b1;
    cmd[c]        <= word;
    @(posedge clk);
    cmd_strobe[c] <= 1'b0;
    wait (done_count[c] == issued[c]);
  endtask

  task automatic run_client(input int c);
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      repeat (rnd_gap[c][i]) @(posedge clk);
      issue_cmd(c, rnd_wr[c][i], rnd_addr[c][i], rnd_data[c][i]);
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      if (!value_ok("cs_n", cs_n, 1'b1))
        main_errors++;
      if (!value_ok("sclk", sclk, 1'b0))
        main_errors++;
      for (int c = 0; c < NC; c++)
      begin
        if (!value_ok($sformatf("rsp[%0d].done", c), rsp[c].done, 1'b0))
          main_errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = mon_errors + main_errors - err_mark;
    tests_run++;
    if (errs == 0)
      $display("test %0d %s: pass", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, errs);
    end
    err_mark = mon_errors + main_errors;
  endtask

  task automatic check_response(input int c);
    string name;
    name = $sformatf("rsp[%0d]", c);
    if (!value_ok({name, ".was_read"}, rsp[c].was_read, exp_rd[c]))
      mon_errors++;
    if (exp_rd[c])
    begin
      if (!value_ok({name, ".data"}, rsp[c].data, ref_regs[exp_addr[c]]))
        mon_errors++;
      last_rd[c] = rsp[c].data;
    end
    else
    begin
      if (!value_ok({name, ".data"}, rsp[c].data, 8'h00))
        mon_errors++;
      // frames go out one at a time, so done order is write order.
      ref_regs[exp_addr[c]] = exp_wdata[c];
    end
    if (first_done < 0)
      first_done = c;
    done_count[c]++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor.
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!rst_n || cs_n)
    begin
      if (!value_ok("sclk", sclk, 1'b0))
        mon_errors++;
    end
    if (!rst_n)
    begin
      if (!value_ok("cs_n", cs_n, 1'b1))
        mon_errors++;
      if (!value_ok("mosi", mosi, 1'b0))
        mon_errors++;
    end
    for (int c = 0; c < NC; c++)
    begin
      if (rsp[c].done)
      begin
        assert (rst_n && done_count[c] < issued[c])
        else
        begin
          $display("client %0d got a done with no command outstanding", c);
          mon_errors++;
        end
        if (rst_n && done_count[c] < issued[c])
          check_response(c);
      end
    end
  end

  // allows every frame of both clients plus reset.
  initial
  begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: run still going after %0d clock cycles", LIMIT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests.
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    rst_n      = 1'b0;
    cmd_strobe = '0;
    cmd        = '0;
    seed       = 32'hbadd;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      for (int c = 0; c < NC; c++)
      begin
        r              = $random(seed);
        rnd_wr[c][i]   = r[0];
        rnd_addr[c][i] = r[3:1];
        rnd_data[c][i] = r[11:4];
        rnd_gap[c][i]  = int'(r[13:12]) % 3;
      end
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    check_idle(10);
    finish_test("idle after reset");

    // both slots pending at once, client 0 goes first.
    fork
      issue_cmd(0, 1'b1, 3'd1, 8'h3c);
      issue_cmd(1, 1'b1, 3'd6, 8'hc3);
    join
    check_idle(4);
    if (!value_ok("first_done", first_done, 0))
      main_errors++;
    finish_test("simultaneous strobes");

    issue_cmd(0, 1'b1, 3'd5, 8'h5a);
    issue_cmd(0, 1'b0, 3'd5, 8'hff);
    if (!value_ok("rsp[0].data", last_rd[0], 8'h5a))
      main_errors++;
    check_idle(4);
    finish_test("write then read");

    fork
      run_client(0);
      run_client(1);
    join
    check_idle(4);
    finish_test("random traffic");

    if (!value_ok("frame_errors", frame_errors, 0))
      main_errors++;
    if (!value_ok("pad_errors", pad_errors, 0))
      main_errors++;
    if (!value_ok("frame_count", frame_count, issued[0] + issued[1]))
      main_errors++;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      if (!value_ok($sformatf("slave regs[%0d]", i), u_slave.regs[i], ref_regs[i]))
        main_errors++;
    end
    finish_test("frame integrity");

    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, mon_errors + main_errors);
    if (tests_failed == 0 && mon_errors + main_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/spi_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_ctrl_settings.svh"

module spi_slave_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output int   frame_errors,
  output int   frame_count,
  output int   pad_errors
);

  localparam int FRAME = `SPI_FRAME_BITS;
  localparam int DATA  = `SPI_DATA_BITS;
  localparam int HEAD  = FRAME - DATA;

  logic [DATA-1:0]           regs [1 << `SPI_ADDR_BITS];
  logic [FRAME-1:0]          rx;
  logic [`SPI_ADDR_BITS-1:0] addr;
  logic                      miso_q = 1'b0;
  int                        nbits;

  ////////////////////////////////////////////////////////////////////////////
  // receive side.
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    for (int i = 0; i < (1 << `SPI_ADDR_BITS); i++)
      regs[i] = '0;
    frame_errors = 0;
    frame_count  = 0;
    pad_errors   = 0;
    nbits        = 0;
    rx           = '0;
    addr         = '0;
    forever
    begin
      @(negedge cs_n);
      nbits = 0;
      while (!cs_n)
      begin
        @(posedge sclk or posedge cs_n);
        if (!cs_n)
        begin
          rx = {rx[FRAME-2:0], mosi};
          nbits++;
          // flag and address are in.
          if (nbits == HEAD)
            addr = rx[`SPI_ADDR_BITS-1:0];
        end
      end
      frame_count++;
      // a read carries zeros after the address.
      if (nbits != FRAME)
        frame_errors++;
      else if (rx[FRAME-1])
        regs[rx[FRAME-2:DATA]] = rx[DATA-1:0];
      else if (rx[DATA-1:0] != '0)
        pad_errors++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit side, one bit per falling edge after the address.
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge sclk)
  begin
    if (!cs_n && nbits >= HEAD && nbits < FRAME)
      miso_q <= regs[addr][FRAME-1-nbits];
    else
      miso_q <= 1'b0;
  end

  assign miso = miso_q;

endmodule

`default_nettype wire

// File: verilog/spi_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_ctrl_settings.svh"

module spi_ctrl_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [`SPI_NUM_CLIENTS-1:0]                  cmd_strobe,
  input  spi_ctrl_pkg::spi_cmd_u [`SPI_NUM_CLIENTS-1:0] cmd,
  input  logic                                         miso,
  output spi_ctrl_pkg::spi_rsp_t [`SPI_NUM_CLIENTS-1:0] rsp,
  output logic                                         sclk,
  output logic                                         cs_n,
  output logic                                         mosi
);

  import spi_ctrl_pkg::*;

  logic                      start;
  spi_cmd_u                  start_cmd;
  logic                      eng_done;
  logic [`SPI_DATA_BITS-1:0] eng_data;

  // clients in, one frame at a time out.
  spi_cmd_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .eng_done   (eng_done),
    .eng_data   (eng_data),
    .start      (start),
    .start_cmd  (start_cmd),
    .rsp        (rsp)
  );

  spi_shift_engine #(
    .half_period (`SPI_HALF_PERIOD)
  ) u_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .cmd     (start_cmd),
    .miso    (miso),
    .done    (eng_done),
    .rd_data (eng_data),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi)
  );

endmodule

`default_nettype wire

// File: verilog/spi_shift_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_ctrl_settings.svh"

module spi_shift_engine #(
  parameter int half_period = `SPI_HALF_PERIOD
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  spi_ctrl_pkg::spi_cmd_u    cmd,
  input  logic                      miso,
  output logic                      done,
  output logic [`SPI_DATA_BITS-1:0] rd_data,
  output logic                      sclk,
  output logic                      cs_n,
  output logic                      mosi
);

  localparam int FRAME = `SPI_FRAME_BITS;
  localparam int DATA  = `SPI_DATA_BITS;
  localparam int DIV_W = (half_period > 1) ? $clog2(half_period) : 1;

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(half_period - 1);
  localparam logic [3:0]       BIT_LAST = 4'(FRAME - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACTIVE,
    ST_FINISH
  } state_t;

  state_t             state;
  logic [DIV_W-1:0]   div_cnt;
  logic [3:0]         bit_cnt;
  logic [FRAME-1:0]   shreg;
  logic [DATA-1:0]    capture;
  logic               tick;
  logic               rise;
  logic               fall;

  ////////////////////////////////////////////////////////////////////////////
  // sclk edges.
  ////////////////////////////////////////////////////////////////////////////

  // sclk toggles every half_period cycles while active.
  assign tick = (state == ST_ACTIVE) && (div_cnt == DIV_LAST);
  assign rise = tick && !sclk;
  assign fall = tick && sclk;

  ////////////////////////////////////////////////////////////////////////////
  // fsm.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      shreg   <= '0;
      done    <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state   <= ST_ACTIVE;
            cs_n    <= 1'b0;
            shreg   <= cmd;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        ST_ACTIVE:
        begin
          if (tick)
          begin
            div_cnt <= '0;
            sclk    <= ~sclk;
          end
          else
            div_cnt <= div_cnt + 1'b1;

          // next bit goes out on the falling edge.
          if (fall)
          begin
            if (bit_cnt == BIT_LAST)
              state <= ST_FINISH;
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              shreg   <= {shreg[FRAME-2:0], 1'b0};
            end
          end
        end
        ST_FINISH:
        begin
          cs_n  <= 1'b1;
          done  <= 1'b1;
          shreg <= '0;
          state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  assign mosi = shreg[FRAME-1];

  ////////////////////////////////////////////////////////////////////////////
  // capture.
  ////////////////////////////////////////////////////////////////////////////

  // last DATA bits of every frame, read or not.
  always_ff @(posedge clk)
  begin
    if (rise)
      capture <= {capture[DATA-2:0], miso};
  end

  assign rd_data = capture;

endmodule

`default_nettype wire

// File: verilog/spi_cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "spi_ctrl_settings.svh"

module spi_cmd_arbiter (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [`SPI_NUM_CLIENTS-1:0]                  cmd_strobe,
  input  spi_ctrl_pkg::spi_cmd_u [`SPI_NUM_CLIENTS-1:0] cmd,
  input  logic                                         eng_done,
  input  logic [`SPI_DATA_BITS-1:0]                    eng_data,
  output logic                                         start,
  output spi_ctrl_pkg::spi_cmd_u                       start_cmd,
  output spi_ctrl_pkg::spi_rsp_t [`SPI_NUM_CLIENTS-1:0] rsp
);

  import spi_ctrl_pkg::*;

  localparam int NC = `SPI_NUM_CLIENTS;

  logic [NC-1:0] pending;
  spi_cmd_u      slot_cmd [NC];
  client_idx_t   last_grant;
  client_idx_t   grant_idx;
  logic          grant_vld;
  logic          busy;
  client_idx_t   owner;
  logic          owner_rd;

  ////////////////////////////////////////////////////////////////////////////
  // slots.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NC; i++)
    begin
      if (cmd_strobe[i])
        slot_cmd[i] <= cmd[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // round robin pick, starting one past the last grant.
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    client_idx_t cand;
    grant_vld = 1'b0;
    grant_idx = last_grant;
    for (int i = 1; i <= NC; i++)
    begin
      cand = client_idx_t'((int'(last_grant) + i) % NC);
      if (!grant_vld && pending[cand])
      begin
        grant_vld = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign start = grant_vld && !busy;

  // a read sends zeros after the address.
  always_comb
  begin
    start_cmd = slot_cmd[grant_idx];
    if (!start_cmd.rd_cmd.wr)
      start_cmd.rd_cmd.pad = '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // in-flight tracking.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending    <= '0;
      busy       <= 1'b0;
      owner      <= '0;
      owner_rd   <= 1'b0;
      // first search after reset begins at client 0.
      last_grant <= client_idx_t'(NC - 1);
    end
    else
    begin
      if (start)
      begin
        busy       <= 1'b1;
        owner      <= grant_idx;
        owner_rd   <= !start_cmd.wr_cmd.wr;
        last_grant <= grant_idx;
      end
      else if (eng_done)
        busy <= 1'b0;

      for (int i = 0; i < NC; i++)
      begin
        if (cmd_strobe[i])
          pending[i] <= 1'b1;
        else if (eng_done && owner == client_idx_t'(i))
          pending[i] <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response to the owner only.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rsp <= '0;
    else
    begin
      for (int i = 0; i < NC; i++)
      begin
        rsp[i] <= '0;
        if (eng_done && owner == client_idx_t'(i))
        begin
          rsp[i].done     <= 1'b1;
          rsp[i].was_read <= owner_rd;
          rsp[i].data     <= owner_rd ? eng_data : '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/spi_ctrl_pkg.sv
`default_nettype none

`include "spi_ctrl_settings.svh"

package spi_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // command word.
  ////////////////////////////////////////////////////////////////////////////

  // write view, wr set.
  typedef struct packed {
    logic                      wr;
    logic [`SPI_ADDR_BITS-1:0] addr;
    logic [`SPI_DATA_BITS-1:0] data;
  } spi_wr_cmd_t;

  // read view, wr clear. pad goes out as zeros while miso is captured.
  typedef struct packed {
    logic                      wr;
    logic [`SPI_ADDR_BITS-1:0] addr;
    logic [`SPI_DATA_BITS-1:0] pad;
  } spi_rd_cmd_t;

  typedef union packed {
    spi_wr_cmd_t wr_cmd;
    spi_rd_cmd_t rd_cmd;
  } spi_cmd_u;

  ////////////////////////////////////////////////////////////////////////////
  // response and client index.
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                      done;
    logic                      was_read;
    logic [`SPI_DATA_BITS-1:0] data;
  } spi_rsp_t;

  typedef logic [$clog2(`SPI_NUM_CLIENTS)-1:0] client_idx_t;

endpackage

`default_nettype wire

// File: verilog/spi_ctrl_settings.svh
`ifndef SPI_CTRL_SETTINGS_SVH
`define SPI_CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// frame layout.
////////////////////////////////////////////////////////////////////////////

// one write flag, the address, then the data byte.
`define SPI_FRAME_BITS 12
`define SPI_DATA_BITS 8
`define SPI_ADDR_BITS 3

////////////////////////////////////////////////////////////////////////////
// system.
////////////////////////////////////////////////////////////////////////////

`define SPI_NUM_CLIENTS 2

// clk cycles per sclk half period.
`define SPI_HALF_PERIOD 4

`endif
